// ==== Makefile ====
# Verilator build for the multiply/divide unit testbench

VERILATOR ?= verilator
TOP       ?= mulDivTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
JOBS      ?= 4

SOURCES := $(shell cat $(FLIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(BUILD_DIR)/$(TOP): $(SOURCES) $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP) -f $(FLIST)

# the binary exits non-zero on $$fatal, so make fails with it
sim: $(BUILD_DIR)/$(TOP)
	./$(BUILD_DIR)/$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== boothMultiplier.sv ====
module boothMultiplier import mulDivPkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       start,
    input  funct3_u    funct3,
    input  logic       word,
    input  dataWord_t  opA,         // multiplicand, rs1
    input  dataWord_t  opB,         // multiplier, rs2
    input  resultTag_t tagIn,
    output logic       idle,
    output logic       pendValid,
    output dataWord_t  pendResult,
    output resultTag_t pendTag,
    input  logic       grant
);

    logic [1:0]          state;
    logic [5:0]          stepCount;
    logic [5:0]          lastStep;
    logic                wordReg;
    logic [1:0]          kindReg;
    logic [accWidth-1:0] multiplicandReg;
    logic [extWidth:0]   multiplierReg;  // extended multiplier with a zero below bit 0
    logic [accWidth-1:0] acc;
    logic [accWidth-1:0] accNext;
    logic                signA;
    logic                signB;
    logic [extWidth-1:0] extA;
    logic [extWidth-1:0] extB;
    dataWord_t           product;

    // mul and mulw are sign blind in the low half, so treat them as signed
    assign signA = funct3.mulView.mulKind != mulKindHighUU;
    assign signB = !(funct3.mulView.mulKind == mulKindHighSU ||
                     funct3.mulView.mulKind == mulKindHighUU);

    always_comb begin
        if (word) begin
            extA = {{(extWidth-32){signA & opA[31]}}, opA[31:0]};  // 33 bits, then filled
            extB = {{(extWidth-32){signB & opB[31]}}, opB[31:0]};
        end else begin
            extA = {{2{signA & opA[63]}}, opA};
            extB = {{2{signB & opB[63]}}, opB};
        end
    end

    boothStep step_i (
        .multiplierBits      (multiplierReg[2:0]),
        .multiplicandAligned (multiplicandReg),
        .partialIn           (acc),
        .partialOut          (accNext)
    );

    assign lastStep = wordReg ? mulStepsWord : mulStepsDouble;

    // ==============================
    // result select
    // ==============================
    always_comb begin
        if (wordReg) begin
            product = {{32{acc[63]}}, acc[63:32]};  // word product lands 32 bits up
        end else if (kindReg == mulKindLow) begin
            product = acc[63:0];
        end else begin
            product = acc[127:64];
        end
    end

    // fsm
    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= stateIdle;
            stepCount <= '0;
        end else begin
            case (state)
                stateIdle: begin
                    if (start) begin
                        state     <= stateBusy;
                        stepCount <= '0;
                    end
                end
                stateBusy: begin
                    if (stepCount == lastStep) state <= statePending;  // select cycle
                    else stepCount <= stepCount + 6'd1;
                end
                statePending: begin
                    if (grant) state <= stateIdle;  // result taken by the bus
                end
                default: state <= stateIdle;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clock) begin
        if (state == stateIdle && start) begin
            wordReg         <= word;
            kindReg         <= funct3.mulView.mulKind;
            multiplicandReg <= {extA, {extWidth{1'b0}}};
            multiplierReg   <= {extB, 1'b0};
            acc             <= '0;
            pendTag         <= tagIn;
        end else if (state == stateBusy) begin
            if (stepCount == lastStep) begin
                pendResult <= product;
            end else begin
                acc           <= accNext;
                multiplierReg <= {{2{multiplierReg[extWidth]}}, multiplierReg[extWidth:2]};
            end
        end
    end

    assign idle      = state == stateIdle;
    assign pendValid = state == statePending;

endmodule

// ==== boothStep.sv ====
module boothStep import mulDivPkg::*; (
    input  logic [2:0]          multiplierBits,       // {b(i+1), b(i), b(i-1)}
    input  logic [accWidth-1:0] multiplicandAligned,  // multiplicand in the top half
    input  logic [accWidth-1:0] partialIn,
    output logic [accWidth-1:0] partialOut
);

    logic [accWidth-1:0] doubled;
    logic [accWidth-1:0] multiple;
    logic [accWidth-1:0] sum;

    // the top bit lost here is only a spare copy of the sign
    assign doubled = multiplicandAligned << 1;

    // radix-4 booth digit select
    always_comb begin
        case (multiplierBits)
            3'b001,
            3'b010: begin
                multiple = multiplicandAligned;               // +1
            end
            3'b011: begin
                multiple = doubled;                           // +2
            end
            3'b100: begin
                multiple = ~doubled + accWidth'(1);           // -2
            end
            3'b101,
            3'b110: begin
                multiple = ~multiplicandAligned + accWidth'(1);  // -1
            end
            default: begin
                multiple = '0;                                // 000 and 111
            end
        endcase
    end

    assign sum = partialIn + multiple;

    // arithmetic shift by two, keeps the running sum signed
    assign partialOut = {{2{sum[accWidth-1]}}, sum[accWidth-1:2]};

endmodule

// ==== flist.f ====
mulDivPkg.sv
boothStep.sv
boothMultiplier.sv
restoringDivider.sv
resultArbiter.sv
mulDivUnit.sv
mulDivTb.sv

// ==== mulDivPkg.sv ====
package mulDivPkg;

    // ==============================
    // widths and word types
    // ==============================
    localparam int dataWidth = 64;
    localparam int tagWidth  = 5;
    localparam int extWidth  = dataWidth + 2;   // operand plus two guard bits for booth
    localparam int accWidth  = 2 * extWidth;    // booth accumulator, 132 bits

    typedef logic [dataWidth-1:0] dataWord_t;
    typedef logic [tagWidth-1:0]  resultTag_t;

    // one funct3 word, read as a multiply or as a divide
    typedef union packed {
        struct packed {
            logic       isDiv;
            logic [1:0] mulKind;    // which half and which signs
        } mulView;
        struct packed {
            logic isDiv;
            logic isRem;            // remainder instead of quotient
            logic isUnsigned;
        } divView;
    } funct3_u;

    localparam logic [1:0] mulKindLow    = 2'b00;  // mul, mulw
    localparam logic [1:0] mulKindHighSS = 2'b01;  // mulh
    localparam logic [1:0] mulKindHighSU = 2'b10;  // mulhsu
    localparam logic [1:0] mulKindHighUU = 2'b11;  // mulhu

    // ==============================
    // cycle counts and indices
    // ==============================
    localparam logic [5:0] mulStepsDouble = 6'd33;  // 65-bit multiplier, two bits a step
    localparam logic [5:0] mulStepsWord   = 6'd17;  // 33-bit multiplier
    localparam logic [6:0] divStepsDouble = 7'd64;
    localparam logic [6:0] divStepsWord   = 7'd32;

    localparam logic unitMul = 1'b0;  // arbiter requester index
    localparam logic unitDiv = 1'b1;

    // unit state codes, fix is used by the divider only
    localparam logic [1:0] stateIdle    = 2'd0;
    localparam logic [1:0] stateBusy    = 2'd1;
    localparam logic [1:0] statePending = 2'd2;
    localparam logic [1:0] stateFix     = 2'd3;

endpackage

// ==== mulDivTb.sv ====
module mulDivTb import mulDivPkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int issueTimeout = 300;   // cycles for a unit to free up
    localparam int drainTimeout = 2000;  // cycles for all results to return

    logic       clock = 1'b0;
    logic       reset;
    logic       issueValid;
    funct3_u    issueFunct3;
    logic       issueWord;
    dataWord_t  issueA;
    dataWord_t  issueB;
    resultTag_t issueTag;
    logic       issueReady;
    logic       resultValid;
    dataWord_t  result;
    resultTag_t resultTag;
    logic       resultReady;

    integer     seed;
    integer     readySeed;
    logic       stallBus;                 // forces back-pressure
    resultTag_t nextTag;
    int         issuedCount;
    int         doneCount;
    logic       outstanding [32];         // scoreboard with one slot per tag
    dataWord_t  expByTag [32];
    string      nameByTag [32];
    logic       holdPrev;                 // bus was offered but stalled last cycle
    dataWord_t  heldResult;
    resultTag_t heldTag;

    mulDivUnit dut_i (.*);

    always #4 clock = ~clock;  // 8 ns period

    // ==============================
    // failure and compare tasks
    // ==============================
    task automatic abortRun(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic checkResult(input string name, input dataWord_t expected,
                               input dataWord_t actual);
        if (actual !== expected)
            abortRun($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic checkTag(input string name, input resultTag_t expected,
                            input resultTag_t actual);
        if (actual !== expected)
            abortRun($sformatf("mismatch %s expected %0d actual %0d", name, expected, actual));
    endtask

    // reference model of the M extension from the ISA rules
    function automatic dataWord_t modelResult(input logic [2:0] op, input logic word,
                                              input dataWord_t a, input dataWord_t b);
        logic [127:0]       wideA;
        logic [127:0]       wideB;
        logic [127:0]       prod;
        logic [31:0]        res32;
        logic signed [31:0] sa32;
        logic signed [31:0] sb32;
        logic signed [63:0] sa64;
        logic signed [63:0] sb64;
        dataWord_t          res;
        sa32 = a[31:0];
        sb32 = b[31:0];
        sa64 = a;
        sb64 = b;
        if (!op[2] && word) begin
            res32 = a[31:0] * b[31:0];  // mulw
            res   = {{32{res32[31]}}, res32};
        end else if (!op[2]) begin
            wideA = (op[1:0] == mulKindHighUU) ? {64'b0, a} : {{64{a[63]}}, a};
            wideB = (op[1:0] == mulKindHighSU || op[1:0] == mulKindHighUU) ?
                    {64'b0, b} : {{64{b[63]}}, b};
            prod  = wideA * wideB;      // mod 2^128 is exact here
            res   = (op[1:0] == mulKindLow) ? prod[63:0] : prod[127:64];
        end else if (word) begin
            if (b[31:0] == 32'h0) res32 = op[1] ? a[31:0] : 32'hffff_ffff;
            else if (!op[0] && a[31:0] == 32'h8000_0000 && b[31:0] == 32'hffff_ffff)
                res32 = op[1] ? 32'h0 : a[31:0];
            else if (op[0]) res32 = op[1] ? a[31:0] % b[31:0] : a[31:0] / b[31:0];
            else res32 = op[1] ? sa32 % sb32 : sa32 / sb32;  // truncates toward zero
            res = {{32{res32[31]}}, res32};
        end else begin
            if (b == 64'h0) res = op[1] ? a : 64'hffff_ffff_ffff_ffff;
            else if (!op[0] && a == 64'h8000_0000_0000_0000 && b == 64'hffff_ffff_ffff_ffff)
                res = op[1] ? 64'h0 : a;
            else if (op[0]) res = op[1] ? a % b : a / b;
            else res = op[1] ? sa64 % sb64 : sa64 / sb64;
        end
        return res;
    endfunction

    // next tag that is not in flight
    function automatic resultTag_t pickTag();
        resultTag_t t;
        t = nextTag;
        while (outstanding[t]) t = t + 5'd1;
        nextTag = t + 5'd1;
        return t;
    endfunction

    // called at posedge + 1 and returns at posedge + 1 after acceptance
    task automatic issueOp(input string name, input logic [2:0] op, input logic word,
                           input dataWord_t a, input dataWord_t b, input int limit);
        resultTag_t tag;
        int         waited;
        tag         = pickTag();
        issueValid  = 1'b1;
        issueFunct3 = op;
        issueWord   = word;
        issueA      = a;
        issueB      = b;
        issueTag    = tag;
        waited      = 0;
        @(negedge clock);
        while (!issueReady) begin
            waited++;
            if (waited >= limit)
                abortRun($sformatf("%s: issue not accepted within %0d cycles", name, limit));
            @(negedge clock);
        end
        expByTag[tag]    = modelResult(op, word, a, b);  // taken on the coming edge
        nameByTag[tag]   = name;
        outstanding[tag] = 1'b1;
        issuedCount++;
        @(posedge clock);
        #1 issueValid = 1'b0;
    endtask

    task automatic waitDrain(input string name);
        int waited;
        waited = 0;
        while (doneCount != issuedCount) begin
            @(posedge clock);
            #1 waited++;
            if (waited > drainTimeout) abortRun($sformatf("%s: results did not return", name));
        end
    endtask

    function automatic dataWord_t randWord();
        return {$random(seed), $random(seed)};
    endfunction

    // ==============================
    // result side sampled mid cycle
    // ==============================
    always @(posedge clock) begin
        #1 resultReady = !stallBus && (($random(readySeed) % 4) != 0);  // ready 3 of 4
    end

    always @(negedge clock) begin
        if (holdPrev) begin  // stalled offer must not move
            if (!resultValid) abortRun("resultValid dropped while resultReady was low");
            checkResult("held result", heldResult, result);
            checkTag("held tag", heldTag, resultTag);
        end
        if (resultValid && resultReady) begin  // transfer on the next edge
            if (!outstanding[resultTag])
                abortRun($sformatf("result returned with tag %0d that was not issued", resultTag));
            checkResult(nameByTag[resultTag], expByTag[resultTag], result);
            outstanding[resultTag] = 1'b0;
            doneCount++;
        end
        holdPrev   = resultValid && !resultReady;
        heldResult = result;
        heldTag    = resultTag;
    end

    // ==============================
    // stimulus
    // ==============================
    initial begin
        dataWord_t   corners [5];
        logic [31:0] rnd;
        logic [2:0]  op;
        seed        = 32'hbc0c4f03;
        readySeed   = 32'hbc0c4f03;
        corners     = '{64'h0, 64'h1, 64'hffff_ffff_ffff_ffff,
                        64'h8000_0000_0000_0000, 64'hffff_ffff_8000_0000};
        reset       = 1'b1;
        issueValid  = 1'b0;
        issueFunct3 = 3'b000;
        issueWord   = 1'b0;
        issueA      = '0;
        issueB      = '0;
        issueTag    = '0;
        resultReady = 1'b0;
        stallBus    = 1'b0;
        nextTag     = '0;
        issuedCount = 0;
        doneCount   = 0;
        holdPrev    = 1'b0;
        for (int t = 0; t < 32; t++) outstanding[t] = 1'b0;
        repeat (5) @(posedge clock);
        #1 reset = 1'b0;

        // idle state of both units after reset
        @(negedge clock);
        if (resultValid !== 1'b0) abortRun("resultValid is not low after reset");
        if (issueReady !== 1'b1) abortRun("issueReady low for multiply after reset");
        @(posedge clock);
        #1 issueFunct3 = 3'b100;
        @(negedge clock);
        if (issueReady !== 1'b1) abortRun("issueReady low for divide after reset");
        @(posedge clock);
        #1;

        for (int i = 0; i < 200; i++) begin  // all eight 64-bit kinds
            rnd = $random(seed);
            issueOp("rv64 random", rnd[2:0], 1'b0, randWord(), randWord(), issueTimeout);
        end
        for (int i = 0; i < 120; i++) begin  // word forms only with mulw or a divide
            rnd = $random(seed);
            op  = rnd[2] ? rnd[2:0] : 3'b000;
            issueOp("word random", op, 1'b1, randWord(), randWord(), issueTimeout);
        end
        for (int k = 0; k < 8; k++)  // corner grid
            for (int x = 0; x < 5; x++)
                for (int y = 0; y < 5; y++) begin
                    issueOp("corner rv64", 3'(k), 1'b0, corners[x], corners[y], issueTimeout);
                    if (k == 0 || k >= 4)
                        issueOp("corner word", 3'(k), 1'b1, corners[x], corners[y], issueTimeout);
                end

        // divide accepted the cycle after a multiply while it is busy
        for (int i = 0; i < 10; i++) begin
            waitDrain("overlap drain");
            rnd = $random(seed);
            issueOp("overlap mul", {1'b0, rnd[1:0]}, 1'b0, randWord(), randWord(), issueTimeout);
            issueOp("overlap div", {1'b1, rnd[3:2]}, rnd[4], randWord(), randWord(), 1);
        end

        // both units finish under back-pressure and must hold
        waitDrain("stall drain");
        @(negedge clock);
        stallBus = 1'b1;
        @(posedge clock);
        #1;
        issueOp("stall mul", 3'b001, 1'b0, randWord(), randWord(), issueTimeout);
        issueOp("stall div", 3'b100, 1'b0, randWord(), randWord(), issueTimeout);
        repeat (int'(divStepsDouble) + 2) @(posedge clock);  // divider latency
        #1;
        if (!resultValid) abortRun("no result offered while the bus was stalled");
        @(negedge clock);
        stallBus = 1'b0;
        @(posedge clock);
        #1;
        waitDrain("final drain");

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== mulDivUnit.sv ====
module mulDivUnit import mulDivPkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       issueValid,
    input  funct3_u    issueFunct3,
    input  logic       issueWord,
    input  dataWord_t  issueA,
    input  dataWord_t  issueB,
    input  resultTag_t issueTag,
    output logic       issueReady,
    output logic       resultValid,
    output dataWord_t  result,
    output resultTag_t resultTag,
    input  logic       resultReady
);

    logic       mulIdle;
    logic       divIdle;
    logic       issueFire;
    logic       mulStart;
    logic       divStart;
    logic       mulPendValid;
    logic       divPendValid;
    dataWord_t  mulPendResult;
    dataWord_t  divPendResult;
    resultTag_t mulPendTag;
    resultTag_t divPendTag;
    logic       mulGrant;
    logic       divGrant;
    logic       selectDiv;

    // ==============================
    // issue steering
    // ==============================
    assign issueReady = issueFunct3.divView.isDiv ? divIdle : mulIdle;
    assign issueFire  = issueValid & issueReady;
    assign mulStart   = issueFire & !issueFunct3.mulView.isDiv;
    assign divStart   = issueFire & issueFunct3.divView.isDiv;

    boothMultiplier mul_i (
        .clock      (clock),
        .reset      (reset),
        .start      (mulStart),
        .funct3     (issueFunct3),
        .word       (issueWord),
        .opA        (issueA),
        .opB        (issueB),
        .tagIn      (issueTag),
        .idle       (mulIdle),
        .pendValid  (mulPendValid),
        .pendResult (mulPendResult),
        .pendTag    (mulPendTag),
        .grant      (mulGrant)
    );

    restoringDivider div_i (
        .clock      (clock),
        .reset      (reset),
        .start      (divStart),
        .funct3     (issueFunct3),
        .word       (issueWord),
        .opA        (issueA),
        .opB        (issueB),
        .tagIn      (issueTag),
        .idle       (divIdle),
        .pendValid  (divPendValid),
        .pendResult (divPendResult),
        .pendTag    (divPendTag),
        .grant      (divGrant)
    );

    resultArbiter arb_i (
        .clock       (clock),
        .reset       (reset),
        .mulPending  (mulPendValid),
        .divPending  (divPendValid),
        .resultReady (resultReady),
        .mulGrant    (mulGrant),
        .divGrant    (divGrant),
        .selectDiv   (selectDiv)
    );

    // shared result bus
    assign resultValid = selectDiv ? divPendValid  : mulPendValid;
    assign result      = selectDiv ? divPendResult : mulPendResult;
    assign resultTag   = selectDiv ? divPendTag    : mulPendTag;

endmodule

// ==== restoringDivider.sv ====
module restoringDivider import mulDivPkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       start,
    input  funct3_u    funct3,
    input  logic       word,
    input  dataWord_t  opA,         // dividend
    input  dataWord_t  opB,         // divisor
    input  resultTag_t tagIn,
    output logic       idle,
    output logic       pendValid,
    output dataWord_t  pendResult,
    output resultTag_t pendTag,
    input  logic       grant
);

    logic [1:0]       state;
    logic [6:0]       iterCount;  // 0 is the load cycle
    logic [6:0]       lastIter;
    logic             wordReg;
    logic             remReg;
    logic             unsignedReg;
    dataWord_t        rawA;
    dataWord_t        rawB;
    dataWord_t        dividend;
    dataWord_t        divisorIn;
    dataWord_t        absA;
    dataWord_t        absB;
    logic             aNeg;
    logic             bNeg;
    dataWord_t        divisor;
    dataWord_t        remainder;
    dataWord_t        quotient;
    logic             negQuot;
    logic             negRem;
    logic             divZero;
    logic             overflow;
    logic [64:0]      shifted;
    logic [65:0]      trial;
    logic             trialOk;
    dataWord_t        fixed;

    // ==============================
    // operand prep from held inputs
    // ==============================
    always_comb begin
        if (wordReg) begin
            dividend  = unsignedReg ? {32'b0, rawA[31:0]} : {{32{rawA[31]}}, rawA[31:0]};
            divisorIn = unsignedReg ? {32'b0, rawB[31:0]} : {{32{rawB[31]}}, rawB[31:0]};
        end else begin
            dividend  = rawA;
            divisorIn = rawB;
        end
    end

    assign aNeg = !unsignedReg & dividend[63];
    assign bNeg = !unsignedReg & divisorIn[63];
    assign absA = aNeg ? -dividend : dividend;
    assign absB = bNeg ? -divisorIn : divisorIn;

    // one shift-subtract step
    assign shifted = {remainder, quotient[63]};
    assign trial   = {1'b0, shifted} - {2'b0, divisor};
    assign trialOk = !trial[65];                 // no borrow, keep the difference

    assign lastIter = wordReg ? divStepsWord : divStepsDouble;

    // sign fix and the riscv corner cases
    always_comb begin
        if (divZero) begin
            fixed = remReg ? dividend : '1;
        end else if (overflow) begin
            fixed = remReg ? '0 : dividend;
        end else if (remReg) begin
            fixed = negRem ? -remainder : remainder;   // remainder follows the dividend
        end else begin
            fixed = negQuot ? -quotient : quotient;
        end
    end

    // fsm
    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= stateIdle;
            iterCount <= '0;
        end else begin
            case (state)
                stateIdle: begin
                    if (start) begin
                        state     <= stateBusy;
                        iterCount <= '0;
                    end
                end
                stateBusy: begin
                    iterCount <= iterCount + 7'd1;
                    if (iterCount == lastIter) state <= stateFix;
                end
                stateFix:     state <= statePending;
                statePending: if (grant) state <= stateIdle;
                default:      state <= stateIdle;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clock) begin
        if (state == stateIdle && start) begin
            rawA        <= opA;
            rawB        <= opB;
            wordReg     <= word;
            remReg      <= funct3.divView.isRem;
            unsignedReg <= funct3.divView.isUnsigned;
            pendTag     <= tagIn;
        end else if (state == stateBusy) begin
            if (iterCount == '0) begin
                divisor   <= absB;
                remainder <= '0;
                quotient  <= wordReg ? {absA[31:0], 32'b0} : absA;  // word dividend at the top
                negQuot   <= aNeg ^ bNeg;
                negRem    <= aNeg;
                divZero   <= divisorIn == '0;
                overflow  <= !unsignedReg && divisorIn == '1 &&
                             (wordReg ? dividend == 64'hffff_ffff_8000_0000
                                      : dividend == 64'h8000_0000_0000_0000);
            end else begin
                remainder <= trialOk ? trial[63:0] : shifted[63:0];  // restore on borrow
                quotient  <= {quotient[62:0], trialOk};
            end
        end else if (state == stateFix) begin
            pendResult <= wordReg ? {{32{fixed[31]}}, fixed[31:0]} : fixed;
        end
    end

    assign idle      = state == stateIdle;
    assign pendValid = state == statePending;

endmodule

// ==== resultArbiter.sv ====
module resultArbiter import mulDivPkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic mulPending,
    input  logic divPending,
    input  logic resultReady,
    output logic mulGrant,
    output logic divGrant,
    output logic selectDiv    // result mux steer
);

    logic lastServed;  // unit that made the last transfer
    logic holding;     // an offer is stalled by back-pressure
    logic heldDiv;
    logic fairPick;

    // round robin only matters when both ask
    always_comb begin
        if (mulPending && divPending) begin
            fairPick = lastServed == unitMul;
        end else begin
            fairPick = divPending;
        end
    end

    // a stalled offer keeps the bus so the result stays stable
    assign selectDiv = holding ? heldDiv : fairPick;

    assign mulGrant = resultReady & mulPending & !selectDiv;
    assign divGrant = resultReady & divPending & selectDiv;

    always_ff @(posedge clock) begin
        if (reset) begin
            lastServed <= unitMul;
            holding    <= 1'b0;
            heldDiv    <= 1'b0;
        end else begin
            if (mulGrant) lastServed <= unitMul;
            else if (divGrant) lastServed <= unitDiv;
            holding <= (mulPending | divPending) & !resultReady;
            heldDiv <= selectDiv;
        end
    end

endmodule
